// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timescale 1ns/1ns -Wno-fatal
TOP       = tb_rsa_wrapper
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== rsa_avm_link.sv ====
module rsa_avm_link import rsa_pkg::*; (
    input  logic                avm_clk,
    input  logic                avm_rst,
    output logic [4:0]          avm_address,
    output logic                avm_read,
    input  logic [31:0]         avm_readdata,
    output logic                avm_write,
    output logic [31:0]         avm_writedata,
    input  logic                avm_waitrequest,
    output logic                start,
    output logic [key_bits-1:0] mod_n,
    output logic [key_bits-1:0] exp_d,
    output logic [key_bits-1:0] base_a,
    input  logic                done,
    input  logic [key_bits-1:0] result
);

    link_state_t         state_q;
    logic [6:0]          byte_cnt;
    logic [key_bits-1:0] res_q;
    logic                rd_done;
    logic                wr_done;
    logic                rx_ready;
    logic                tx_ready;

    // A transfer completes in the first cycle with waitrequest low.
    assign rd_done  = (state_q == read_byte) && !avm_waitrequest;
    assign wr_done  = (state_q == write_byte) && !avm_waitrequest;
    assign rx_ready = (state_q == poll_rx) && !avm_waitrequest && avm_readdata[rx_ok_bit];
    assign tx_ready = (state_q == poll_tx) && !avm_waitrequest && avm_readdata[tx_ok_bit];

    assign start = (state_q == start_calc);

    // Bit 247 is the top of the 31 bytes that go back to the host.
    assign avm_writedata = {24'd0, res_q[key_bits-9 -: 8]};

    // ==================================================
    // Bus sequencing
    // ==================================================

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_q     <= poll_rx;
            byte_cnt    <= '0;
            avm_address <= status_base;
            avm_read    <= 1'b1;
            avm_write   <= 1'b0;
        end else begin
            case (state_q)
                poll_rx: begin
                    // Keep reading status until a byte is waiting.
                    if (rx_ready) begin
                        avm_address <= rx_base;
                        state_q     <= read_byte;
                    end
                end
                read_byte: begin
                    if (rd_done) begin
                        if (byte_cnt == 3 * key_bytes - 1) begin
                            byte_cnt <= '0;
                            avm_read <= 1'b0;
                            state_q  <= start_calc;
                        end else begin
                            byte_cnt    <= byte_cnt + 1'b1;
                            avm_address <= status_base;
                            state_q     <= poll_rx;
                        end
                    end
                end
                start_calc: begin
                    state_q <= wait_calc;
                end
                wait_calc: begin
                    if (done) begin
                        avm_address <= status_base;
                        avm_read    <= 1'b1;
                        state_q     <= poll_tx;
                    end
                end
                poll_tx: begin
                    if (tx_ready) begin
                        avm_read    <= 1'b0;
                        avm_write   <= 1'b1;
                        avm_address <= tx_base;
                        state_q     <= write_byte;
                    end
                end
                write_byte: begin
                    if (wr_done) begin
                        avm_write   <= 1'b0;
                        avm_read    <= 1'b1;
                        avm_address <= status_base;
                        if (byte_cnt == out_bytes - 1) begin
                            // Block finished, go back for the next key and data.
                            byte_cnt <= '0;
                            state_q  <= poll_rx;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state_q  <= poll_tx;
                        end
                    end
                end
                default: begin
                    state_q <= poll_rx;
                end
            endcase
        end
    end

    // ==================================================
    // Operand and result shift registers
    // ==================================================

    // The three operands form one long shift chain, so the first byte
    // read ends up at the top of the modulus.
    always_ff @(posedge avm_clk) begin
        if (rd_done) begin
            {mod_n, exp_d, base_a} <= {mod_n[key_bits-9:0], exp_d, base_a, avm_readdata[7:0]};
        end
        if ((state_q == wait_calc) && done) begin
            res_q <= result;
        end else if (wr_done) begin
            res_q <= res_q << 8;
        end
    end

endmodule

// ==== rsa_core.sv ====
module rsa_core import rsa_pkg::*; (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [key_bits-1:0] mod_n,
    input  logic [key_bits-1:0] exp_d,
    input  logic [key_bits-1:0] base_a,
    output logic                done,
    output logic [key_bits-1:0] result
);

    core_state_t                 state_q;
    logic [$clog2(key_bits)-1:0] round_cnt;
    logic                        waiting;
    logic                        sq_phase;
    logic                        mul_start;
    logic                        mul_done;
    logic [key_bits-1:0]         op_a;
    logic [key_bits-1:0]         op_b;
    logic [key_bits-1:0]         product;
    logic [key_bits-1:0]         acc_q;
    logic [key_bits-1:0]         pow_q;
    logic [key_bits-1:0]         exp_q;

    // One doubling step modulo n, valid for x below n.
    function automatic logic [key_bits-1:0] double_mod(input logic [key_bits-1:0] x,
                                                       input logic [key_bits-1:0] n);
        logic [key_bits:0] x2;
        logic [key_bits:0] diff;
        x2   = {x, 1'b0};
        diff = x2 - {1'b0, n};
        if (x2 >= {1'b0, n}) begin
            return diff[key_bits-1:0];
        end
        return x2[key_bits-1:0];
    endfunction

    rsa_montgomery i_rsa_montgomery (
        .avm_clk   (avm_clk),
        .avm_rst   (avm_rst),
        .mul_start (mul_start),
        .op_a      (op_a),
        .op_b      (op_b),
        .mod_n     (mod_n),
        .mul_done  (mul_done),
        .product   (product)
    );

    assign done = (state_q == rsa_pkg::done);

    // ==================================================
    // Control
    // ==================================================

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_q   <= idle;
            round_cnt <= '0;
            waiting   <= 1'b0;
            sq_phase  <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            case (state_q)
                idle: begin
                    if (start) begin
                        round_cnt <= '0;
                        state_q   <= to_mont;
                    end
                end
                to_mont: begin
                    round_cnt <= round_cnt + 1'b1;
                    if (round_cnt == key_bits - 1) begin
                        waiting  <= 1'b0;
                        sq_phase <= 1'b0;
                        state_q  <= exp_step;
                    end
                end
                exp_step: begin
                    if (!waiting) begin
                        // A clear exponent bit skips straight to the square.
                        if (sq_phase || exp_q[0]) begin
                            mul_start <= 1'b1;
                            waiting   <= 1'b1;
                        end else begin
                            sq_phase <= 1'b1;
                        end
                    end else if (mul_done) begin
                        waiting  <= 1'b0;
                        sq_phase <= !sq_phase;
                        // Stop once no set bits remain above the current one.
                        if (sq_phase && (exp_q[key_bits-1:1] == '0)) begin
                            state_q <= from_mont;
                        end
                    end
                end
                from_mont: begin
                    if (!waiting) begin
                        mul_start <= 1'b1;
                        waiting   <= 1'b1;
                    end else if (mul_done) begin
                        waiting <= 1'b0;
                        state_q <= rsa_pkg::done;
                    end
                end
                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

    // ==================================================
    // Datapath
    // ==================================================

    always_ff @(posedge avm_clk) begin
        case (state_q)
            idle: begin
                if (start) begin
                    acc_q <= key_bits'(1);
                    pow_q <= base_a;
                    exp_q <= exp_d;
                end
            end
            to_mont: begin
                // After key_bits doublings acc holds R mod n and pow holds aR mod n.
                acc_q <= double_mod(acc_q, mod_n);
                pow_q <= double_mod(pow_q, mod_n);
            end
            exp_step: begin
                if (!waiting) begin
                    op_a <= sq_phase ? pow_q : acc_q;
                    op_b <= pow_q;
                end else if (mul_done) begin
                    if (sq_phase) begin
                        pow_q <= product;
                        exp_q <= exp_q >> 1;
                    end else begin
                        acc_q <= product;
                    end
                end
            end
            from_mont: begin
                if (!waiting) begin
                    op_a <= acc_q;
                    op_b <= key_bits'(1);
                end else if (mul_done) begin
                    result <= product;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== rsa_montgomery.sv ====
module rsa_montgomery import rsa_pkg::*; (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                mul_start,
    input  logic [key_bits-1:0] op_a,
    input  logic [key_bits-1:0] op_b,
    input  logic [key_bits-1:0] mod_n,
    output logic                mul_done,
    output logic [key_bits-1:0] product
);

    logic [key_bits-1:0]         a_q;
    logic [key_bits-1:0]         b_q;
    logic [key_bits-1:0]         n_q;
    logic [key_bits+1:0]         acc_q;
    logic [key_bits+1:0]         sum_ab;
    logic [key_bits+1:0]         sum_n;
    logic [key_bits+1:0]         acc_sub;
    logic [$clog2(key_bits)-1:0] bit_cnt;
    logic                        busy;
    logic                        fin;

    // The accumulator stays below 2n, so two extra bits hold every sum.
    always_comb begin
        sum_ab  = acc_q + (a_q[0] ? {2'b00, b_q} : '0);
        sum_n   = sum_ab[0] ? sum_ab + {2'b00, n_q} : sum_ab;
        acc_sub = acc_q - {2'b00, n_q};
    end

    // One bit of op_a per cycle, then one cycle for the final subtraction.
    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy     <= 1'b0;
            fin      <= 1'b0;
            bit_cnt  <= '0;
            mul_done <= 1'b0;
        end else begin
            fin      <= 1'b0;
            mul_done <= fin;
            if (mul_start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == key_bits - 1) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (mul_start) begin
            a_q   <= op_a;
            b_q   <= op_b;
            n_q   <= mod_n;
            acc_q <= '0;
        end else if (busy) begin
            // sum_n is even here, so the shift divides exactly by two.
            a_q   <= a_q >> 1;
            acc_q <= sum_n >> 1;
        end
        if (fin) begin
            product <= (acc_q >= {2'b00, n_q}) ? acc_sub[key_bits-1:0] : acc_q[key_bits-1:0];
        end
    end

endmodule

// ==== rsa_pkg.sv ====
package rsa_pkg;

    // ==================================================
    // Key and block sizes
    // ==================================================

    // Width of the modulus, the exponent and every data block.
    localparam int key_bits  = 256;
    localparam int key_bytes = key_bits / 8;

    // The top byte of a plaintext block is always zero, so it is not sent.
    localparam int out_bytes = key_bytes - 1;

    // ==================================================
    // Serial link register map
    // ==================================================

    localparam logic [4:0] rx_base     = 5'd0;
    localparam logic [4:0] tx_base     = 5'd4;
    localparam logic [4:0] status_base = 5'd8;

    // Bit positions in the status register.
    localparam int rx_ok_bit = 7;
    localparam int tx_ok_bit = 6;

    // ==================================================
    // State encodings
    // ==================================================

    typedef enum logic [2:0] {
        poll_rx,
        read_byte,
        start_calc,
        wait_calc,
        poll_tx,
        write_byte
    } link_state_t;

    typedef enum logic [2:0] {
        idle,
        to_mont,
        exp_step,
        from_mont,
        done
    } core_state_t;

endpackage

// ==== rsa_stimulus.txt ====
# Columns: name, modulus, exponent, ciphertext, expected plaintext.
# All values in hex, most significant digit first.
textbook_3233 ca1 ac1 ae6 41
stallings_187 bb 17 b 58
tiny_33 21 3 10 4
mersenne_pow2 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 9e3779b97f4a7c15f39cc0605cedc8341082276bf3a27251f86c6a11d0c18e2d 20 0000000200000000000000000000000000000000000000000000000000000000
cube_full c3a5f0e1d2b48769aa55cc33f00f1e2d3c4b5a69788796a5b4c3d2e1f0123457 3 0000000000000000000000000000000000000000000100000000000000000001 0001000000000000000000030000000000000000000300000000000000000001
minus_one_odd f1e2d3c4b5a69788796a5b4c3d2e1f00ffeeddccbbaa99887766554433221101 d1b54a32d192ed03e1f0a2b3c4d5e6f708192a3b4c5d6e7f8091a2b3c4d5e6f7 f1e2d3c4b5a69788796a5b4c3d2e1f00ffeeddccbbaa99887766554433221100 f1e2d3c4b5a69788796a5b4c3d2e1f00ffeeddccbbaa99887766554433221100
minus_one_even f1e2d3c4b5a69788796a5b4c3d2e1f00ffeeddccbbaa99887766554433221101 d1b54a32d192ed03e1f0a2b3c4d5e6f708192a3b4c5d6e7f8091a2b3c4d5e6f6 f1e2d3c4b5a69788796a5b4c3d2e1f00ffeeddccbbaa99887766554433221100 1

// ==== rsa_wrapper.sv ====
module rsa_wrapper import rsa_pkg::*; (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);

    logic                start;
    logic                done;
    logic [key_bits-1:0] mod_n;
    logic [key_bits-1:0] exp_d;
    logic [key_bits-1:0] base_a;
    logic [key_bits-1:0] result;

    // Bus side. Gathers the operands and sends the plaintext back.
    rsa_avm_link i_rsa_avm_link (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .start           (start),
        .mod_n           (mod_n),
        .exp_d           (exp_d),
        .base_a          (base_a),
        .done            (done),
        .result          (result)
    );

    rsa_core i_rsa_core (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (start),
        .mod_n   (mod_n),
        .exp_d   (exp_d),
        .base_a  (base_a),
        .done    (done),
        .result  (result)
    );

endmodule

// ==== src.f ====
rsa_pkg.sv
rsa_montgomery.sv
rsa_core.sv
rsa_avm_link.sv
rsa_wrapper.sv
tb_rsa_assert.sv
tb_rsa_wrapper.sv

// ==== tb_rsa_assert.sv ====
module tb_rsa_assert import rsa_pkg::*; (
    input logic        avm_clk,
    input logic        avm_rst,
    input logic [4:0]  avm_address,
    input logic        avm_read,
    input logic        avm_write,
    input logic [31:0] avm_writedata,
    input logic        avm_waitrequest
);

    timeunit 1ns;
    timeprecision 1ns;

    read_write_exclusive: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else $error("avm_read and avm_write are high together.");

    // A stalled request keeps its address, direction and data.
    request_held: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_read) && $stable(avm_write) &&
            $stable(avm_writedata))
        else $error("A request changed while avm_waitrequest was high.");

    write_to_tx_only: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write |-> avm_address == tx_base)
        else $error("A write went to an address other than the transmit register.");

endmodule

bind rsa_wrapper tb_rsa_assert i_tb_rsa_assert (
    .avm_clk         (avm_clk),
    .avm_rst         (avm_rst),
    .avm_address     (avm_address),
    .avm_read        (avm_read),
    .avm_write       (avm_write),
    .avm_writedata   (avm_writedata),
    .avm_waitrequest (avm_waitrequest)
);

// ==== tb_rsa_wrapper.sv ====
module tb_rsa_wrapper import rsa_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    logic        avm_clk;
    logic        avm_rst;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic [31:0] avm_readdata;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest;

    // Bytes the host has sent wait in rx_q, bytes sent back land in tx_q.
    logic [7:0] rx_q[$];
    logic [7:0] tx_q[$];
    int         rx_holdoff;
    int         tx_holdoff;
    int         tx_count;
    logic       expect_tx;

    rsa_wrapper i_rsa_wrapper (.*);

    initial avm_clk = 1'b0;
    always #20 avm_clk = ~avm_clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Run stopped at time %0t.", $time);
    endtask

    task automatic check_value(input string name, input logic [key_bits-1:0] expected,
                               input logic [key_bits-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Mostly short gaps, and now and then a long one.
    function automatic int next_holdoff();
        if ($urandom_range(0, 7) == 0) begin
            return $urandom_range(20, 80);
        end
        return $urandom_range(0, 3);
    endfunction

    // ==================================================
    // Serial link register block
    // ==================================================

    initial begin
        logic stall;
        logic rx_ok;
        logic tx_ok;
        void'($urandom(92110));
        avm_waitrequest = 1'b0;
        avm_readdata    = '0;
        rx_holdoff      = next_holdoff();
        tx_holdoff      = next_holdoff();
        forever begin
            @(posedge avm_clk);
            #2;
            rx_holdoff      = (rx_holdoff > 0) ? rx_holdoff - 1 : 0;
            tx_holdoff      = (tx_holdoff > 0) ? tx_holdoff - 1 : 0;
            rx_ok           = (rx_q.size() > 0) && (rx_holdoff == 0);
            tx_ok           = (tx_holdoff == 0);
            stall           = ($urandom_range(0, 9) < 3);
            avm_waitrequest = stall;
            avm_readdata    = $urandom;
            // A request seen here without a stall completes at the next edge.
            if (!stall && avm_read) begin
                if (avm_address == status_base) begin
                    avm_readdata[rx_ok_bit] = rx_ok;
                    avm_readdata[tx_ok_bit] = tx_ok;
                end else if (avm_address == rx_base) begin
                    if (!rx_ok) begin
                        abort_run("The DUT read the receive register while it was not ready.");
                    end
                    avm_readdata[7:0] = rx_q.pop_front();
                    rx_holdoff        = next_holdoff();
                end else begin
                    abort_run("The DUT read an address outside the register map.");
                end
            end
            if (!stall && avm_write) begin
                if (!tx_ok) begin
                    abort_run("The DUT wrote a byte while transmit-ready was low.");
                end
                if (!expect_tx || rx_q.size() != 0 || tx_count >= out_bytes) begin
                    abort_run("The DUT wrote a byte while no complete result was due.");
                end
                tx_q.push_back(avm_writedata[7:0]);
                tx_count++;
                tx_holdoff = next_holdoff();
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    task automatic run_test(input string name, input logic [key_bits-1:0] mod_val,
                            input logic [key_bits-1:0] exp_val,
                            input logic [key_bits-1:0] ct_val,
                            input logic [key_bits-1:0] pt_val);
        logic [3*key_bits-1:0] operands;
        logic [key_bits-1:0]   got;
        int                    cycles;
        @(negedge avm_clk);
        tx_q.delete();
        tx_count  = 0;
        expect_tx = 1'b1;
        operands  = {mod_val, exp_val, ct_val};
        for (int i = 3 * key_bytes - 1; i >= 0; i--) begin
            rx_q.push_back(operands[8*i +: 8]);
        end
        cycles = 0;
        while (tx_q.size() < out_bytes) begin
            @(negedge avm_clk);
            cycles++;
            if (cycles > 400000) begin
                abort_run($sformatf("Timeout: test %s never sent back a full result.", name));
            end
        end
        got = '0;
        foreach (tx_q[i]) begin
            got = {got[key_bits-9:0], tx_q[i]};
        end
        check_value(name, {8'd0, pt_val[key_bits-9:0]}, got);
    endtask

    initial begin
        int                  fd;
        int                  tests;
        string               line;
        string               test_name;
        logic [8*32-1:0]     name_bits;
        logic [key_bits-1:0] mod_val;
        logic [key_bits-1:0] exp_val;
        logic [key_bits-1:0] ct_val;
        logic [key_bits-1:0] pt_val;
        tx_count    = 0;
        expect_tx   = 1'b0;
        tests       = 0;
        avm_rst     = 1'b1;
        repeat (3) @(posedge avm_clk);
        #2;
        avm_rst = 1'b0;
        fd = $fopen("rsa_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open rsa_stimulus.txt for reading.");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%s %h %h %h %h", name_bits, mod_val, exp_val, ct_val,
                        pt_val) != 5) begin
                abort_run($sformatf("Malformed line in rsa_stimulus.txt: %s", line));
            end
            test_name = string'(name_bits);
            tests++;
            run_test(test_name, mod_val, exp_val, ct_val, pt_val);
        end
        $fclose(fd);
        if (tests == 0) begin
            abort_run("rsa_stimulus.txt holds no tests.");
        end
        // Any stray write after the last block is caught by the register block.
        repeat (200) @(negedge avm_clk);
        $display("No errors");
        $finish;
    end

endmodule
